// File: branch_subsystem.f
+incdir+src
src/rv_isa_pkg.sv
src/branch_pkg.sv
src/branch_decoder.sv
src/branch_unit.sv
src/link_bank.sv
src/return_stack.sv
src/branch_subsystem.sv
dv/branch_subsystem_tb.sv

// File: dv/branch_subsystem_tb.sv
`include "branch_config.svh"

module branch_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Sum of the cycles spent by all tests
    localparam int test_cycles = 400;
    localparam int reset_cycles = 16;
    localparam int cycle_limit = 2 * test_cycles + reset_cycles;

    logic                  clk;
    logic                  rst_n;
    logic                  issue;
    logic [31:0]           instruction;
    logic [31:0]           pc;
    logic [31:0]           rs1_value;
    logic [31:0]           rs2_value;
    logic [31:0]           predicted_pc;
    branch_pkg::instr_id_t issue_id;
    branch_pkg::instr_id_t wb_id;
    logic                  resolve;
    logic                  taken;
    logic                  flush;
    logic [31:0]           redirect_pc;
    logic [31:0]           link_value;
    logic                  done_next_cycle;
    branch_pkg::instr_id_t done_id;
    logic [31:0]           ras_top;
    logic                  ras_empty;

    logic [31:0] lfsr_state = 32'd7556;
    string       test_name = "reset";
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          cycle_count = 0;

    // Branch expectation {valid, taken, flush, redirect}
    logic [34:0] br_q[$];
    // Stack operation {call, return, pc+4}
    logic [33:0] ras_q[$];
    logic [34:0] br_exp;
    logic [34:0] br_now;
    logic [2:0]  hints;
    logic [33:0] ras_op;
    logic [31:0] model_ras [`BR_RAS_DEPTH];
    int          model_ptr;
    int          model_count;
    logic [31:0] link_expect [`BR_ID_COUNT];

    branch_subsystem i_branch_subsystem (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////
    // Random numbers

    function automatic logic next_rand_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], next_rand_bit()};
        end
        return value;
    endfunction

    function automatic logic [31:0] boundary_value(input logic [1:0] idx);
        case (idx)
            2'd0:    return 32'h80000000;
            2'd1:    return 32'h7fffffff;
            2'd2:    return 32'hffffffff;
            default: return 32'h00000000;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Reference model

    function automatic logic [34:0] expect_branch(input logic [31:0] instr, input logic [31:0] ipc,
                                                  input logic [31:0] a, input logic [31:0] b,
                                                  input logic [31:0] pred);
        logic        valid;
        logic        take;
        logic [31:0] target;
        logic [31:0] redirect;
        valid = 1'b0;
        take = 1'b0;
        target = '0;
        if (instr[6:0] == rv_isa_pkg::OP_BRANCH) begin
            target = ipc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            valid = 1'b1;
            case (instr[14:12])
                3'b000:  take = (a == b);
                3'b001:  take = (a != b);
                3'b100:  take = ($signed(a) < $signed(b));
                3'b101:  take = ($signed(a) >= $signed(b));
                3'b110:  take = (a < b);
                3'b111:  take = (a >= b);
                default: valid = 1'b0;
            endcase
        end else if (instr[6:0] == rv_isa_pkg::OP_JAL) begin
            valid = 1'b1;
            take = 1'b1;
            target = ipc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        end else if (instr[6:0] == rv_isa_pkg::OP_JALR && instr[14:12] == 3'b000) begin
            valid = 1'b1;
            take = 1'b1;
            target = (a + {{20{instr[31]}}, instr[31:20]}) & ~32'd1;
        end
        if (!valid) begin
            return '0;
        end
        redirect = take ? target : ipc + 32'd4;
        return {1'b1, take, redirect[31:1] != pred[31:1], redirect};
    endfunction

    // Hint bits {call, return, link write}
    function automatic logic [2:0] jump_hints(input logic [31:0] instr);
        logic is_jalr;
        logic jump;
        logic rd_link;
        logic rs1_link;
        is_jalr  = (instr[6:0] == rv_isa_pkg::OP_JALR) && (instr[14:12] == 3'b000);
        jump     = is_jalr || (instr[6:0] == rv_isa_pkg::OP_JAL);
        rd_link  = (instr[11:7] == rv_isa_pkg::reg_ra) || (instr[11:7] == rv_isa_pkg::reg_t0);
        rs1_link = (instr[19:15] == rv_isa_pkg::reg_ra) || (instr[19:15] == rv_isa_pkg::reg_t0);
        return {jump && rd_link, is_jalr && rs1_link && !rd_link, jump && instr[11:7] != 5'd0};
    endfunction

    // Circular stack model
    task automatic apply_ras_op(input logic [33:0] op);
        if (op[33] && op[32] && model_count > 0) begin
            model_ras[model_ptr] = op[31:0];
        end else if (op[33]) begin
            model_ptr = (model_ptr + 1) % `BR_RAS_DEPTH;
            model_ras[model_ptr] = op[31:0];
            if (model_count < `BR_RAS_DEPTH) begin
                model_count++;
            end
        end else if (op[32] && model_count > 0) begin
            model_ptr = (model_ptr + `BR_RAS_DEPTH - 1) % `BR_RAS_DEPTH;
            model_count--;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Checker sampled on the falling edge

    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("resolve", 32'd0, {31'd0, resolve});
            check_value("flush", 32'd0, {31'd0, flush});
            check_value("ras_empty", 32'd1, {31'd0, ras_empty});
            check_value("done", 32'd0, {31'd0, done_next_cycle});
            br_q.delete();
            ras_q.delete();
            model_ptr = 0;
            model_count = 0;
        end else begin
            br_now = issue ? expect_branch(instruction, pc, rs1_value, rs2_value, predicted_pc)
                           : '0;
            hints = issue ? jump_hints(instruction) : 3'b000;
            br_q.push_back(br_now);
            ras_q.push_back({hints[2], hints[1], pc + 32'd4});
            check_value("done", {31'd0, hints[0]}, {31'd0, done_next_cycle});
            if (hints[0]) begin
                check_value("done_id", 32'(issue_id), 32'(done_id));
            end
            if (br_q.size() == 2) begin
                br_exp = br_q.pop_front();
                check_value("resolve", {31'd0, br_exp[34]}, {31'd0, resolve});
                check_value("taken", {31'd0, br_exp[33]}, {31'd0, taken});
                check_value("flush", {31'd0, br_exp[32]}, {31'd0, flush});
                if (br_exp[34]) begin
                    check_value("redirect_pc", br_exp[31:0], redirect_pc);
                end
            end
            if (ras_q.size() == 3) begin
                ras_op = ras_q.pop_front();
                apply_ras_op(ras_op);
                check_value("ras_empty", {31'd0, model_count == 0}, {31'd0, ras_empty});
                check_value("ras_top", model_count > 0 ? model_ras[model_ptr] : 32'd0, ras_top);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic issue_instr(input logic [31:0] instr, input logic [31:0] ipc,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] pred, input branch_pkg::instr_id_t id);
        @(posedge clk);
        #1;
        issue = 1'b1;
        instruction = instr;
        pc = ipc;
        rs1_value = a;
        rs2_value = b;
        predicted_pc = pred;
        issue_id = id;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            issue = 1'b0;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        idle_cycles(3);
        $display("Test %s finished with %0d errors", test_name, error_count - test_errors);
    endtask

    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = rand_bits(32);
        return {r[31:2], 2'b00};
    endfunction

    function automatic branch_pkg::instr_id_t random_id();
        return branch_pkg::instr_id_t'(rand_bits(3));
    endfunction

    // Random branch or jump of kind 0 to 2
    function automatic logic [31:0] random_control(input int kind);
        logic [31:0] r;
        logic [2:0]  f3;
        r = rand_bits(32);
        f3 = r[14:12];
        if (f3 == 3'b010 || f3 == 3'b011) begin
            f3 = f3 ^ 3'b100;
        end
        case (kind)
            0:       return {r[31:15], f3, r[11:7], rv_isa_pkg::OP_BRANCH};
            1:       return {r[31:12], r[11:7], rv_isa_pkg::OP_JAL};
            default: return {r[31:15], 3'b000, r[11:7], rv_isa_pkg::OP_JALR};
        endcase
    endfunction

    task automatic conditional_test();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ipc;
        begin_test("conditional");
        for (int i = 0; i < 200; i++) begin
            instr = random_control(0);
            ipc = random_pc();
            case (rand_bits(2))
                2'd0: begin
                    a = rand_bits(32);
                    b = a;
                end
                2'd1: begin
                    a = boundary_value(2'(rand_bits(2)));
                    b = boundary_value(2'(rand_bits(2)));
                end
                default: begin
                    a = rand_bits(32);
                    b = rand_bits(32);
                end
            endcase
            issue_instr(instr, ipc, a, b, ipc + 32'd4, random_id());
        end
        finish_test();
    endtask

    task automatic jump_test();
        logic [31:0] instr;
        begin_test("jumps");
        for (int i = 0; i < 40; i++) begin
            instr = random_control(1 + (i % 2));
            issue_instr(instr, random_pc(), rand_bits(32), rand_bits(32), random_pc(),
                        random_id());
        end
        finish_test();
    endtask

    task automatic mispredict_test();
        logic [31:0] instr;
        logic [31:0] ipc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] good;
        logic [34:0] model;
        begin_test("mispredict");
        for (int i = 0; i < 25; i++) begin
            instr = random_control(i % 3);
            ipc = random_pc();
            a = rand_bits(32);
            b = (i % 4 == 0) ? a : rand_bits(32);
            model = expect_branch(instr, ipc, a, b, 32'd0);
            // Bit 0 differences must not flush
            good = model[31:0] ^ {31'd0, next_rand_bit()};
            issue_instr(instr, ipc, a, b, good, random_id());
            issue_instr(instr, ipc, a, b, good ^ {29'(rand_bits(29)), 3'b010}, random_id());
        end
        finish_test();
    endtask

    task automatic link_test();
        logic [31:0] ipc;
        logic [31:0] r;
        begin_test("link_writeback");
        for (int id = 0; id < `BR_ID_COUNT; id++) begin
            ipc = random_pc();
            r = rand_bits(32);
            link_expect[id] = ipc + 32'd4;
            issue_instr({r[31:12], 5'd10 + 5'(id), rv_isa_pkg::OP_JAL}, ipc, r, r, ipc + 32'd4,
                        branch_pkg::instr_id_t'(id));
        end
        // No writeback from these two
        issue_instr(random_control(0), random_pc(), 32'd1, 32'd2, 32'd0, 3'd0);
        r = rand_bits(32);
        issue_instr({r[31:12], 5'd0, rv_isa_pkg::OP_JAL}, random_pc(), r, r, 32'd0, 3'd1);
        idle_cycles(1);
        for (int id = 0; id < `BR_ID_COUNT; id++) begin
            wb_id = branch_pkg::instr_id_t'(id);
            @(negedge clk);
            check_value("link_value", link_expect[id], link_value);
            idle_cycles(1);
        end
        finish_test();
    endtask

    task automatic return_stack_test();
        logic [31:0] ipc;
        begin_test("return_stack");
        for (int i = 0; i < `BR_RAS_DEPTH + 2; i++) begin
            ipc = 32'h1000 + 32'(i * 64);
            issue_instr({20'h00040, rv_isa_pkg::reg_ra, rv_isa_pkg::OP_JAL}, ipc, '0, '0,
                        ipc + 32'h40, random_id());
        end
        for (int i = 0; i < `BR_RAS_DEPTH + 3; i++) begin
            issue_instr({12'h000, rv_isa_pkg::reg_ra, 3'b000, 5'd0, rv_isa_pkg::OP_JALR},
                        32'h4000, ras_top, '0, ras_top, random_id());
        end
        finish_test();
    endtask

    task automatic non_branch_test();
        logic [6:0]  opcodes [8];
        logic [31:0] r;
        begin_test("non_branch");
        opcodes = '{rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_FENCE, rv_isa_pkg::OP_IMM,
                    rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_STORE, rv_isa_pkg::OP_REG,
                    rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_SYSTEM};
        for (int i = 0; i < 40; i++) begin
            r = rand_bits(32);
            if (i % 5 == 0) begin
                r = {r[31:15], 2'b01, r[12], r[11:7], rv_isa_pkg::OP_BRANCH};
            end else if (i % 5 == 1) begin
                r = {r[31:15], r[14:13], 1'b1, r[11:7], rv_isa_pkg::OP_JALR};
            end else begin
                r = {r[31:7], opcodes[3'(rand_bits(3))]};
            end
            issue_instr(r, random_pc(), rand_bits(32), rand_bits(32), '0, random_id());
        end
        finish_test();
    endtask

    initial begin
        rst_n = 1'b0;
        issue = 1'b0;
        instruction = '0;
        pc = '0;
        rs1_value = '0;
        rs2_value = '0;
        predicted_pc = '0;
        issue_id = '0;
        wb_id = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        conditional_test();
        jump_test();
        mispredict_test();
        link_test();
        return_stack_test();
        non_branch_test();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the branch subsystem testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary -f branch_subsystem.f --top-module branch_subsystem_tb -o sim_branch &&
./obj_dir/sim_branch | grep "All checks passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: src/branch_config.svh
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// Data and address width
`define BR_XLEN 32

// Instruction ids that can be in flight at once
`define BR_ID_COUNT 8

// Return address stack entries
`define BR_RAS_DEPTH 4

`endif

// File: src/branch_decoder.sv
module branch_decoder (
    input  logic [31:0]            instruction,
    output branch_pkg::branch_op_e op,
    output rv_isa_pkg::br_funct3_e cond_fn3,
    output logic [31:0]            offset,
    output logic                   is_call,
    output logic                   is_return,
    output logic                   writes_link
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [31:0]         imm_b;
    logic [31:0]         imm_j;
    logic [31:0]         imm_i;
    logic                is_jump;
    logic                rd_is_link;
    logic                rs1_is_link;

    // Instruction fields
    assign opcode = rv_isa_pkg::opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign rd     = instruction[11:7];
    assign rs1    = instruction[19:15];

    //////////////////////////////////////////////////
    // Immediates

    // B and J formats carry a half-word offset with bit 0 implied zero
    assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};
    assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};

    //////////////////////////////////////////////////
    // Classification

    always_comb begin
        op = branch_pkg::BR_NONE;
        case (opcode)
            rv_isa_pkg::OP_BRANCH: begin
                case (funct3)
                    rv_isa_pkg::F3_BEQ,
                    rv_isa_pkg::F3_BNE,
                    rv_isa_pkg::F3_BLT,
                    rv_isa_pkg::F3_BGE,
                    rv_isa_pkg::F3_BLTU,
                    rv_isa_pkg::F3_BGEU: op = branch_pkg::BR_COND;
                    default:             op = branch_pkg::BR_NONE;
                endcase
            end
            rv_isa_pkg::OP_JAL: begin
                op = branch_pkg::BR_JAL;
            end
            rv_isa_pkg::OP_JALR: begin
                // Only funct3 000 is a legal JALR
                if (funct3 == 3'b000) begin
                    op = branch_pkg::BR_JALR;
                end
            end
            default: begin
                op = branch_pkg::BR_NONE;
            end
        endcase
    end

    always_comb begin
        case (op)
            branch_pkg::BR_JAL:  offset = imm_j;
            branch_pkg::BR_JALR: offset = imm_i;
            default:             offset = imm_b;
        endcase
    end

    assign cond_fn3 = rv_isa_pkg::br_funct3_e'(funct3);

    //////////////////////////////////////////////////
    // Return address stack hints

    assign is_jump     = (op == branch_pkg::BR_JAL) || (op == branch_pkg::BR_JALR);
    assign rd_is_link  = (rd == rv_isa_pkg::reg_ra) || (rd == rv_isa_pkg::reg_t0);
    assign rs1_is_link = (rs1 == rv_isa_pkg::reg_ra) || (rs1 == rv_isa_pkg::reg_t0);

    assign is_call     = is_jump & rd_is_link;
    assign is_return   = (op == branch_pkg::BR_JALR) & rs1_is_link & ~rd_is_link;
    assign writes_link = is_jump & (rd != 5'd0);

endmodule

// File: src/branch_pkg.sv
`include "branch_config.svh"

package branch_pkg;

    // Operation class handed from decode to the branch unit
    typedef enum logic [2:0] {
        BR_COND = 3'd0,
        BR_JAL  = 3'd1,
        BR_JALR = 3'd2,
        BR_NONE = 3'd3
    } branch_op_e;

    // Tag of an in-flight instruction
    typedef logic [$clog2(`BR_ID_COUNT)-1:0] instr_id_t;

endpackage

// File: src/branch_subsystem.sv
`include "branch_config.svh"

module branch_subsystem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  logic [31:0]           instruction,
    input  logic [`BR_XLEN-1:0]   pc,
    input  logic [`BR_XLEN-1:0]   rs1_value,
    input  logic [`BR_XLEN-1:0]   rs2_value,
    input  logic [`BR_XLEN-1:0]   predicted_pc,
    input  branch_pkg::instr_id_t issue_id,
    input  branch_pkg::instr_id_t wb_id,
    output logic                  resolve,
    output logic                  taken,
    output logic                  flush,
    output logic [`BR_XLEN-1:0]   redirect_pc,
    output logic [`BR_XLEN-1:0]   link_value,
    output logic                  done_next_cycle,
    output branch_pkg::instr_id_t done_id,
    output logic [`BR_XLEN-1:0]   ras_top,
    output logic                  ras_empty
);

    branch_pkg::branch_op_e op;
    rv_isa_pkg::br_funct3_e cond_fn3;
    logic [`BR_XLEN-1:0]    offset;
    logic                   is_call;
    logic                   is_return;
    logic                   writes_link;
    logic                   link_write;
    logic                   call_ex;
    logic                   return_ex;
    logic [`BR_XLEN-1:0]    next_pc;

    //////////////////////////////////////////////////
    // Decode side

    branch_decoder i_branch_decoder (
        .instruction (instruction),
        .op          (op),
        .cond_fn3    (cond_fn3),
        .offset      (offset),
        .is_call     (is_call),
        .is_return   (is_return),
        .writes_link (writes_link)
    );

    branch_unit i_branch_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .op           (op),
        .cond_fn3     (cond_fn3),
        .offset       (offset),
        .pc           (pc),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .predicted_pc (predicted_pc),
        .is_call      (is_call),
        .is_return    (is_return),
        .resolve      (resolve),
        .taken        (taken),
        .flush        (flush),
        .call_ex      (call_ex),
        .return_ex    (return_ex),
        .target_pc    (),
        .next_pc      (next_pc),
        .redirect_pc  (redirect_pc)
    );

    //////////////////////////////////////////////////
    // Writeback and return prediction

    assign link_write = issue & writes_link;

    link_bank i_link_bank (
        .clk             (clk),
        .rst_n           (rst_n),
        .write_en        (link_write),
        .write_id        (issue_id),
        .wb_id           (wb_id),
        .pc              (pc),
        .link_value      (link_value),
        .done_next_cycle (done_next_cycle),
        .done_id         (done_id)
    );

    // Calls push their own return address
    return_stack i_return_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (call_ex),
        .pop       (return_ex),
        .push_addr (next_pc),
        .ras_top   (ras_top),
        .ras_empty (ras_empty)
    );

endmodule

// File: src/branch_unit.sv
`include "branch_config.svh"

module branch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue,
    input  branch_pkg::branch_op_e op,
    input  rv_isa_pkg::br_funct3_e cond_fn3,
    input  logic [`BR_XLEN-1:0]    offset,
    input  logic [`BR_XLEN-1:0]    pc,
    input  logic [`BR_XLEN-1:0]    rs1_value,
    input  logic [`BR_XLEN-1:0]    rs2_value,
    input  logic [`BR_XLEN-1:0]    predicted_pc,
    input  logic                   is_call,
    input  logic                   is_return,
    output logic                   resolve,
    output logic                   taken,
    output logic                   flush,
    output logic                   call_ex,
    output logic                   return_ex,
    output logic [`BR_XLEN-1:0]    target_pc,
    output logic [`BR_XLEN-1:0]    next_pc,
    output logic [`BR_XLEN-1:0]    redirect_pc
);

    localparam logic [`BR_XLEN-1:0] instr_bytes = 'd4;

    logic                valid_op;
    logic                is_jump;
    logic [`BR_XLEN:0]   rs1_ext;
    logic [`BR_XLEN:0]   rs2_ext;
    logic [`BR_XLEN:0]   diff;
    logic                less_than;
    logic                equal;
    logic                compare;
    logic [`BR_XLEN-1:0] jump_base;
    logic [`BR_XLEN-1:0] jump_sum;

    // Execute stage state
    logic                jump_ex;
    logic                compare_ex;
    logic                invert_ex;
    logic [`BR_XLEN-1:0] predicted_ex;

    assign valid_op = issue & (op != branch_pkg::BR_NONE);
    assign is_jump  = (op == branch_pkg::BR_JAL) || (op == branch_pkg::BR_JALR);

    //////////////////////////////////////////////////
    // Decode-cycle compare

    // Extra top bit is the sign for signed compares, zero for unsigned
    assign rs1_ext = {~cond_fn3[1] & rs1_value[`BR_XLEN-1], rs1_value};
    assign rs2_ext = {~cond_fn3[1] & rs2_value[`BR_XLEN-1], rs2_value};
    assign diff    = rs1_ext - rs2_ext;

    assign less_than = diff[`BR_XLEN];
    assign equal     = (rs1_value == rs2_value);
    assign compare   = cond_fn3[2] ? less_than : equal;

    // Target addition
    assign jump_base = (op == branch_pkg::BR_JALR) ? rs1_value : pc;
    assign jump_sum  = jump_base + offset;

    //////////////////////////////////////////////////
    // Execute stage registers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resolve      <= 1'b0;
            jump_ex      <= 1'b0;
            compare_ex   <= 1'b0;
            invert_ex    <= 1'b0;
            call_ex      <= 1'b0;
            return_ex    <= 1'b0;
            target_pc    <= '0;
            next_pc      <= '0;
            predicted_ex <= '0;
        end else begin
            resolve      <= valid_op;
            jump_ex      <= is_jump;
            compare_ex   <= compare;
            invert_ex    <= cond_fn3[0];
            call_ex      <= issue & is_call;
            return_ex    <= issue & is_return;
            // JALR may produce an odd sum, jumps always land on even addresses
            target_pc    <= {jump_sum[`BR_XLEN-1:1], 1'b0};
            next_pc      <= pc + instr_bytes;
            predicted_ex <= predicted_pc;
        end
    end

    //////////////////////////////////////////////////
    // Resolution

    assign taken       = resolve & (jump_ex | (compare_ex ^ invert_ex));
    assign redirect_pc = taken ? target_pc : next_pc;

    // Bit 0 of the predicted PC is don't-care
    assign flush = resolve &
                   (redirect_pc[`BR_XLEN-1:1] != predicted_ex[`BR_XLEN-1:1]);

endmodule

// File: src/link_bank.sv
`include "branch_config.svh"

module link_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  write_en,
    input  branch_pkg::instr_id_t write_id,
    input  branch_pkg::instr_id_t wb_id,
    input  logic [`BR_XLEN-1:0]   pc,
    output logic [`BR_XLEN-1:0]   link_value,
    output logic                  done_next_cycle,
    output branch_pkg::instr_id_t done_id
);

    localparam logic [`BR_XLEN-1:0] link_step = 'd4;

    logic [`BR_XLEN-1:0]     bank [`BR_ID_COUNT];
    logic [`BR_ID_COUNT-1:0] written;

    // Return address storage with one slot per id
    always_ff @(posedge clk) begin
        if (write_en) begin
            bank[write_id] <= pc + link_step;
        end
    end

    // Slots holding a value since reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
        end else if (write_en) begin
            written[write_id] <= 1'b1;
        end
    end

    assign link_value = written[wb_id] ? bank[wb_id] : '0;

    // Writeback announced while the value is being captured
    assign done_next_cycle = write_en;
    assign done_id         = write_id;

endmodule

// File: src/return_stack.sv
`include "branch_config.svh"

module return_stack (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic                pop,
    input  logic [`BR_XLEN-1:0] push_addr,
    output logic [`BR_XLEN-1:0] ras_top,
    output logic                ras_empty
);

    localparam int ptr_w   = $clog2(`BR_RAS_DEPTH);
    localparam int count_w = $clog2(`BR_RAS_DEPTH + 1);

    localparam logic [ptr_w-1:0]   ptr_last   = ptr_w'(`BR_RAS_DEPTH - 1);
    localparam logic [count_w-1:0] count_full = count_w'(`BR_RAS_DEPTH);

    logic [`BR_XLEN-1:0] entries [`BR_RAS_DEPTH];
    logic [ptr_w-1:0]    top_ptr;
    logic [ptr_w-1:0]    ptr_up;
    logic [ptr_w-1:0]    ptr_down;
    logic [count_w-1:0]  count;
    logic                empty;
    logic                replace_top;
    logic                grow;
    logic                shrink;

    assign empty = (count == '0);

    // Circular pointer neighbours
    assign ptr_up   = (top_ptr == ptr_last) ? '0 : top_ptr + 1'b1;
    assign ptr_down = (top_ptr == '0) ? ptr_last : top_ptr - 1'b1;

    // Push with pop swaps the top, on an empty stack it is a plain push
    assign replace_top = push & pop & ~empty;
    assign grow        = push & ~replace_top;
    assign shrink      = pop & ~push & ~empty;

    always_ff @(posedge clk) begin
        if (replace_top) begin
            entries[top_ptr] <= push_addr;
        end else if (grow) begin
            entries[ptr_up] <= push_addr;
        end
    end

    //////////////////////////////////////////////////
    // Pointer and occupancy

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (grow) begin
            top_ptr <= ptr_up;
            // Full stack drops its oldest entry
            if (count != count_full) begin
                count <= count + 1'b1;
            end
        end else if (shrink) begin
            top_ptr <= ptr_down;
            count   <= count - 1'b1;
        end
    end

    assign ras_top   = empty ? '0 : entries[top_ptr];
    assign ras_empty = empty;

endmodule

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes in instruction[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Conditional branch funct3
    // bit 2 picks less-than, bit 1 unsigned, bit 0 inverts the result
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_funct3_e;

    // Link registers used by the call and return hints
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

endpackage
